// File: div_defs.svh
////////////////////////////////////////////////////////////////////////////
// Divider sizing shared by the package and all RTL
// DIV_STEPS must equal DIV_W, one quotient bit per step
// DIV_CNT_W must hold the value DIV_STEPS
////////////////////////////////////////////////////////////////////////////
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// Operand and result width
`define DIV_W       64

// 32-bit ops and the Y register
`define DIV_HALF_W  32

// Iterations per division
`define DIV_STEPS   64
`define DIV_CNT_W   7      // Counts 0 to DIV_STEPS

`endif

// File: div_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the divider and its testbench
// Op encoding: bit 1 marks a 32-bit op, bit 0 a signed op
////////////////////////////////////////////////////////////////////////////
`include "div_defs.svh"

package div_pkg;

   typedef enum logic [1:0] {
      OP_UDIVX = 2'b00,   // 64/64 unsigned
      OP_SDIVX = 2'b01,   // 64/64 signed
      OP_UDIV  = 2'b10,   // {Y,rs1}/rs2 unsigned
      OP_SDIV  = 2'b11    // {Y,rs1}/rs2 signed
   } div_op_e;

   // Result word, whole or split in halves for 32-bit ops
   typedef union packed {
      logic [`DIV_W-1:0] q64;
      struct packed {
         logic [`DIV_HALF_W-1:0] hi;
         logic [`DIV_HALF_W-1:0] lo;
      } half;
   } div_result_u;

   typedef struct packed {
      logic zero;   // Result word is zero
      logic neg;    // Bit 63 of result
      logic ovf;    // 32-bit quotient saturated
      logic dbz;    // Divisor was zero
   } div_flags_s;

endpackage

// File: div_yreg.sv
////////////////////////////////////////////////////////////////////////////
// Single Y register, upper half of the 32-bit dividend
// Writes are held off while a division is busy
// New value visible on y the cycle after the write handshake
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "div_defs.svh"

module div_yreg (
   input  logic                   clk,
   input  logic                   arst_n,
   // Software write port
   input  logic                   wr_valid,
   output logic                   wr_ready,
   input  logic [`DIV_HALF_W-1:0] wr_data,
   // From sequencer
   input  logic                   busy,
   // Readback and operand formation
   output logic [`DIV_HALF_W-1:0] y
);

   logic wr_en;   // Write handshake

   // Operand in use, no updates until the result is taken
   assign wr_ready = ~busy;
   assign wr_en    = wr_valid & wr_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         y <= '0;
      end else if (wr_en) begin
         y <= wr_data;
      end
   end

endmodule

// File: div_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Divider sequencer: idle, run, finish, done
// One division at a time; req_ready only in idle
// Zero divisor skips the run phase
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "div_defs.svh"

module div_ctrl import div_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   // Request handshake
   input  logic    req_valid,
   output logic    req_ready,
   input  div_op_e req_op,
   // Operand status from datapath
   input  logic    rs1_sign,
   input  logic    rs2_sign,
   input  logic    rs2_zero,
   input  logic    rem_neg,
   // Datapath and formatter steering
   output logic    load,
   output logic    step,
   output logic    sub,
   output logic    finish,
   output logic    is32,
   output logic    is_signed,
   output logic    neg_q,
   output logic    dbz,
   // Result handshake
   output logic    res_valid,
   input  logic    res_ready,
   output logic    busy
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_RUN  = 2'd1;
   localparam logic [1:0] ST_FIN  = 2'd2;
   localparam logic [1:0] ST_DONE = 2'd3;
   localparam logic [`DIV_CNT_W-1:0] LAST_STEP = `DIV_CNT_W'(`DIV_STEPS - 1);

   logic [1:0]            state;
   logic [1:0]            state_nxt;
   logic [`DIV_CNT_W-1:0] cnt;         // Steps done
   logic                  op32;        // Decoded request
   logic                  op_signed;
   logic                  is32_q;      // Held for the whole division
   logic                  signed_q;

   assign op32      = (req_op == OP_UDIV) || (req_op == OP_SDIV);
   assign op_signed = (req_op == OP_SDIVX) || (req_op == OP_SDIV);

   assign req_ready = (state == ST_IDLE);
   assign busy      = ~req_ready;
   assign load      = req_valid & req_ready;   // Datapath takes operands here
   assign step      = (state == ST_RUN);
   assign finish    = (state == ST_FIN);
   assign res_valid = (state == ST_DONE);

   // Non-restoring: subtract after a positive remainder, add after a negative one
   assign sub = ~rem_neg;

   // While idle the request itself steers operand formation
   assign is32      = req_ready ? op32 : is32_q;
   assign is_signed = req_ready ? op_signed : signed_q;

   //////////////////////////////////////////////////////////////////////////
   // Next state
   //////////////////////////////////////////////////////////////////////////
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: if (load) state_nxt = rs2_zero ? ST_FIN : ST_RUN;
         ST_RUN:  if (cnt == LAST_STEP) state_nxt = ST_FIN;
         ST_FIN:  state_nxt = ST_DONE;
         default: if (res_ready) state_nxt = ST_IDLE;   // Held until taken
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= ST_IDLE;
         cnt      <= '0;
         is32_q   <= 1'b0;
         signed_q <= 1'b0;
         neg_q    <= 1'b0;
         dbz      <= 1'b0;
      end else begin
         state <= state_nxt;
         if (load) begin
            cnt      <= '0;
            is32_q   <= op32;
            signed_q <= op_signed;
            neg_q    <= op_signed & (rs1_sign ^ rs2_sign);   // Quotient sign
            dbz      <= rs2_zero;
         end else if (step) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

// File: div_datapath.sv
////////////////////////////////////////////////////////////////////////////
// Magnitude divider, one quotient bit per step
// Operands sampled on load only, signs fixed later by the formatter
// Remainder is not returned
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "div_defs.svh"

module div_datapath (
   input  logic                   clk,
   input  logic                   load,
   input  logic                   step,
   input  logic                   sub,
   input  logic                   is32,
   input  logic                   is_signed,
   input  logic [`DIV_W-1:0]      rs1,
   input  logic [`DIV_W-1:0]      rs2,
   input  logic [`DIV_HALF_W-1:0] y,
   output logic                   rs1_sign,
   output logic                   rs2_sign,
   output logic                   rs2_zero,
   output logic                   rem_neg,
   output logic [`DIV_W-1:0]      q_mag
);

   logic [`DIV_W-1:0]   dvd;        // Formed dividend
   logic [`DIV_W-1:0]   dvs;        // Formed divisor
   logic [`DIV_W-1:0]   dvd_mag;
   logic [`DIV_W-1:0]   dvs_mag;
   logic [2*`DIV_W-1:0] rq;         // Remainder:quotient
   logic                rem_sign;   // Sign bit above rq remainder half
   logic [`DIV_W-1:0]   x;          // Divisor magnitude
   logic [`DIV_W+1:0]   sh;         // Shifted remainder, 2 guard bits
   logic [`DIV_W+1:0]   sum;

   //////////////////////////////////////////////////////////////////////////
   // Operand formation
   //////////////////////////////////////////////////////////////////////////
   always_comb begin
      if (is32) begin
         dvd = {y, rs1[`DIV_HALF_W-1:0]};   // Y supplies upper half
         dvs = {{`DIV_HALF_W{is_signed & rs2[`DIV_HALF_W-1]}}, rs2[`DIV_HALF_W-1:0]};
      end else begin
         dvd = rs1;
         dvs = rs2;
      end
   end

   assign rs1_sign = dvd[`DIV_W-1];
   assign rs2_sign = dvs[`DIV_W-1];
   assign rs2_zero = ~|dvs;

   // Most negative value maps to 2**63, still fits unsigned
   assign dvd_mag = (is_signed && rs1_sign) ? -dvd : dvd;
   assign dvs_mag = (is_signed && rs2_sign) ? -dvs : dvs;

   //////////////////////////////////////////////////////////////////////////
   // Non-restoring step
   //////////////////////////////////////////////////////////////////////////
   // Next dividend bit shifts in from the quotient half
   assign sh  = {rem_sign, rq[2*`DIV_W-1:`DIV_W-1]};
   assign sum = sub ? sh - {2'b00, x} : sh + {2'b00, x};

   always_ff @(posedge clk) begin
      if (load) begin
         rq       <= {{`DIV_W{1'b0}}, dvd_mag};
         rem_sign <= 1'b0;
         x        <= dvs_mag;
      end else if (step) begin
         // Quotient bit set when the new remainder stays non-negative
         rq       <= {sum[`DIV_W-1:0], rq[`DIV_W-2:0], ~sum[`DIV_W+1]};
         rem_sign <= sum[`DIV_W+1];
      end
   end

   assign rem_neg = rem_sign;
   assign q_mag   = rq[`DIV_W-1:0];   // Exact after the last step

endmodule

// File: div_fmt.sv
////////////////////////////////////////////////////////////////////////////
// Result formatter: sign fix-up, 32-bit saturation, flags
// Output word and flags change only on finish
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "div_defs.svh"

module div_fmt import div_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              finish,
   input  logic              is32,
   input  logic              is_signed,
   input  logic              neg_q,
   input  logic              dbz,
   input  logic [`DIV_W-1:0] q_mag,
   output div_result_u       res_data,
   output div_flags_s        res_flags
);

   div_result_u q_sgn;     // Signed quotient
   div_result_u res_nxt;
   logic        ovf;

   always_comb begin
      q_sgn.q64   = neg_q ? -q_mag : q_mag;
      res_nxt.q64 = q_sgn.q64;   // 64-bit ops pass through
      ovf         = 1'b0;
      if (dbz) begin
         res_nxt.q64 = '0;
      end else if (is32 && !is_signed) begin
         ovf              = |q_mag[`DIV_W-1:`DIV_HALF_W];
         res_nxt.half.hi  = '0;
         res_nxt.half.lo  = ovf ? '1 : q_mag[`DIV_HALF_W-1:0];
      end else if (is32) begin
         // Fits only if upper 33 bits all match
         ovf = (q_sgn.q64[`DIV_W-1:`DIV_HALF_W-1] != '0) &&
               (q_sgn.q64[`DIV_W-1:`DIV_HALF_W-1] != '1);
         if (!ovf) begin
            res_nxt.half.hi = {`DIV_HALF_W{q_sgn.half.lo[`DIV_HALF_W-1]}};
         end else if (neg_q) begin
            res_nxt.half.hi = '1;
            res_nxt.half.lo = {1'b1, {(`DIV_HALF_W-1){1'b0}}};   // Sign-extended min
         end else begin
            res_nxt.half.hi = '0;
            res_nxt.half.lo = {1'b0, {(`DIV_HALF_W-1){1'b1}}};   // Max positive
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res_data  <= '0;
         res_flags <= '0;
      end else if (finish) begin
         res_data       <= res_nxt;
         res_flags.zero <= (res_nxt.q64 == '0);
         res_flags.neg  <= res_nxt.q64[`DIV_W-1];
         res_flags.ovf  <= ovf;
         res_flags.dbz  <= dbz;
      end
   end

endmodule

// File: div_top.sv
////////////////////////////////////////////////////////////////////////////
// Iterative divider top: udivx, sdivx, udiv, sdiv
// Result 66 cycles after request, 2 with a zero divisor
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "div_defs.svh"

module div_top import div_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   // Request
   input  logic                   req_valid,
   output logic                   req_ready,
   input  div_op_e                req_op,
   input  logic [`DIV_W-1:0]      req_rs1,
   input  logic [`DIV_W-1:0]      req_rs2,
   // Result
   output logic                   res_valid,
   input  logic                   res_ready,
   output div_result_u            res_data,
   output div_flags_s             res_flags,
   // Y register
   input  logic                   y_wr_valid,
   output logic                   y_wr_ready,
   input  logic [`DIV_HALF_W-1:0] y_wr_data,
   output logic [`DIV_HALF_W-1:0] y_value
);

   logic              load;
   logic              step;
   logic              sub;
   logic              finish;
   logic              is32;
   logic              is_signed;
   logic              neg_q;
   logic              dbz;
   logic              busy;
   logic              rs1_sign;
   logic              rs2_sign;
   logic              rs2_zero;
   logic              rem_neg;
   logic [`DIV_W-1:0] q_mag;   // Unsigned quotient to formatter

   div_yreg u_yreg (
      .clk(clk), .arst_n(arst_n),
      .wr_valid(y_wr_valid), .wr_ready(y_wr_ready), .wr_data(y_wr_data),
      .busy(busy), .y(y_value)
   );

   div_ctrl u_ctrl (
      .clk(clk), .arst_n(arst_n),
      .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
      .rs1_sign(rs1_sign), .rs2_sign(rs2_sign), .rs2_zero(rs2_zero),
      .rem_neg(rem_neg), .load(load), .step(step), .sub(sub), .finish(finish),
      .is32(is32), .is_signed(is_signed), .neg_q(neg_q), .dbz(dbz),
      .res_valid(res_valid), .res_ready(res_ready), .busy(busy)
   );

   div_datapath u_datapath (
      .clk(clk), .load(load), .step(step), .sub(sub),
      .is32(is32), .is_signed(is_signed),
      .rs1(req_rs1), .rs2(req_rs2), .y(y_value),
      .rs1_sign(rs1_sign), .rs2_sign(rs2_sign), .rs2_zero(rs2_zero),
      .rem_neg(rem_neg), .q_mag(q_mag)
   );

   div_fmt u_fmt (
      .clk(clk), .arst_n(arst_n), .finish(finish),
      .is32(is32), .is_signed(is_signed), .neg_q(neg_q), .dbz(dbz),
      .q_mag(q_mag), .res_data(res_data), .res_flags(res_flags)
   );

endmodule

// File: div_props.sv
////////////////////////////////////////////////////////////////////////////
// Handshake and latency properties bound into div_top
// Latency check covers non-zero divisors only
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "div_defs.svh"

module div_props import div_pkg::*; (
   input logic        clk,
   input logic        arst_n,
   input logic        req_valid,
   input logic        req_ready,
   input logic        rs2_zero,
   input logic        res_valid,
   input logic        res_ready,
   input div_result_u res_data
);

   logic req_hs_nz;   // Request taken with a usable divisor

   assign req_hs_nz = req_valid & req_ready & ~rs2_zero;

   // Result frozen under back-pressure
   a_res_stable: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && !res_ready |=> $stable(res_data))
      else $error("res_data changed while the result was stalled");

   // Load, 64 steps, format
   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      $past(req_hs_nz, `DIV_STEPS + 2) |-> $rose(res_valid))
      else $error("res_valid did not rise 66 cycles after the request");

   // Stalled result stays pending and blocks new requests
   a_one_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && !res_ready |=> res_valid && !req_ready)
      else $error("Result dropped or req_ready high while a result is pending");

endmodule

bind div_top div_props u_props (
   .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req_ready(req_ready),
   .rs2_zero(rs2_zero), .res_valid(res_valid), .res_ready(res_ready), .res_data(res_data)
);

// File: tb_div.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for div_top
// Reference uses SV division truncated toward zero
// 64-bit signed min / -1 is never generated
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "div_defs.svh"

module tb_div import div_pkg::*; ();

   logic                   clk;
   logic                   arst_n;
   logic                   req_valid, req_ready, res_valid, res_ready;
   logic                   y_wr_valid, y_wr_ready;
   div_op_e                req_op;
   logic [`DIV_W-1:0]      req_rs1, req_rs2;
   logic [`DIV_HALF_W-1:0] y_wr_data, y_value;
   logic [`DIV_HALF_W-1:0] y_model;     // Expected Y
   div_result_u            res_data;
   div_flags_s             res_flags;
   int                     val_errs;
   int                     proto_errs;
   bit                     y_hold;      // Raise a Y write once a division runs

   div_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic next_cycle();
      @(posedge clk);
      #2;   // Drive and sample point
   endtask

   task automatic stop_with_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Something failed");
      $finish;
   endtask

   task automatic cmp_result(input string name, input div_result_u got, input div_result_u exp);
      if (got !== exp) begin
         val_errs++;
         $display("** Error %0d ns: %s = %h, expected %h", $time, name, got.q64, exp.q64);
      end
   endtask

   task automatic cmp_flags(input string name, input div_flags_s got, input div_flags_s exp);
      if (got !== exp) begin
         val_errs++;
         $display("** Error %0d ns: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic cmp_y(input string name, input logic [`DIV_HALF_W-1:0] got,
                        input logic [`DIV_HALF_W-1:0] exp);
      if (got !== exp) begin
         val_errs++;
         $display("** Error %0d ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////////
   function automatic void ref_div(input div_op_e op, input logic [`DIV_W-1:0] rs1, rs2,
                                   input logic [`DIV_HALF_W-1:0] y,
                                   output div_result_u data, output div_flags_s flags);
      logic [`DIV_W-1:0] a;
      logic [`DIV_W-1:0] b;
      longint            q;
      bit                w32;
      bit                sgn;
      w32   = (op == OP_UDIV) || (op == OP_SDIV);
      sgn   = (op == OP_SDIVX) || (op == OP_SDIV);
      a     = w32 ? {y, rs1[`DIV_HALF_W-1:0]} : rs1;
      b     = rs2;
      if (w32) b = sgn ? longint'(int'(rs2[`DIV_HALF_W-1:0])) : rs2[`DIV_HALF_W-1:0];
      flags = '0;
      q     = 0;
      if (b == 0) flags.dbz = 1'b1;
      else if (sgn) q = $signed(a) / $signed(b);
      else q = a / b;
      if (w32 && !sgn && q[`DIV_W-1:`DIV_HALF_W] != 0) begin
         q         = 64'h0000_0000_FFFF_FFFF;
         flags.ovf = 1'b1;
      end else if (w32 && sgn && (q > 64'sd2147483647 || q < -64'sd2147483648)) begin
         q         = (q < 0) ? 64'hFFFF_FFFF_8000_0000 : 64'h0000_0000_7FFF_FFFF;
         flags.ovf = 1'b1;
      end
      data.q64   = q;
      flags.zero = (q == 0);
      flags.neg  = q[`DIV_W-1];
   endfunction

   task automatic write_y(input logic [`DIV_HALF_W-1:0] data);
      int n;
      n          = 0;
      y_wr_valid = 1'b1;
      y_wr_data  = data;
      while (!y_wr_ready) begin
         next_cycle();
         n++;
         if (n > 100) stop_with_timeout("y_wr_ready");
      end
      next_cycle();   // Write handshake edge
      y_wr_valid = 1'b0;
      y_model    = data;
      cmp_y("y_value", y_value, y_model);
   endtask

   task automatic issue(input div_op_e op, input logic [`DIV_W-1:0] rs1, rs2);
      int n;
      n         = 0;
      req_valid = 1'b1;
      req_op    = op;
      req_rs1   = rs1;
      req_rs2   = rs2;
      while (!req_ready) begin
         next_cycle();
         n++;
         if (n > 10) stop_with_timeout("req_ready");
      end
      next_cycle();
      req_valid = 1'b0;
   endtask

   // One division with the result held back for stall cycles
   task automatic run_div(input div_op_e op, input logic [`DIV_W-1:0] rs1, rs2, input int stall);
      div_result_u exp_d;
      div_flags_s  exp_f;
      int          lat;
      int          exp_lat;
      ref_div(op, rs1, rs2, y_model, exp_d, exp_f);
      exp_lat = exp_f.dbz ? 2 : `DIV_STEPS + 2;
      issue(op, rs1, rs2);
      y_wr_valid = y_hold;
      lat        = 1;   // Edges from handshake to first possible transfer
      while (!res_valid) begin
         if (y_wr_ready) begin
            proto_errs++;
            $display("Y write port open during a division at %0d ns", $time);
         end
         cmp_y("y_value", y_value, y_model);
         next_cycle();
         lat++;
         if (lat > exp_lat + 2) stop_with_timeout("res_valid");
      end
      if (lat != exp_lat) begin
         proto_errs++;
         $display("Result after %0d cycles instead of %0d", lat, exp_lat);
      end
      repeat (stall) begin
         cmp_result("res_data", res_data, exp_d);
         if (!res_valid || req_ready) begin
            proto_errs++;
            $display("Result dropped or request taken under back-pressure at %0d ns", $time);
         end
         next_cycle();
      end
      cmp_result("res_data", res_data, exp_d);
      cmp_flags("res_flags", res_flags, exp_f);
      res_ready = 1'b1;
      next_cycle();
      res_ready = 1'b0;
      if (res_valid || !req_ready) begin
         proto_errs++;
         $display("Divider not idle after the result handshake at %0d ns", $time);
      end
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////////
   task automatic test_div64();
      logic [`DIV_W-1:0] a;
      logic [`DIV_W-1:0] b;
      for (int i = 0; i < 16; i++) begin
         a = {$urandom, $urandom} >> 1;                           // Positive
         b = {$urandom, $urandom} >> (1 + $urandom % 61);
         if (b == 0) b = 64'd3;
         if (i[0]) a = -a;
         if (i[1]) b = -b;
         run_div(i[2] ? OP_SDIVX : OP_UDIVX, a, b, $urandom % 6);   // Random stall
      end
   endtask

   task automatic test_div32();
      logic [`DIV_HALF_W-1:0] lo;
      for (int i = 0; i < 8; i++) begin
         if (i[0]) begin
            // Small dividend and even divisor of magnitude 2 or more
            write_y(i[1] ? '1 : '0);
            lo = i[1] ? ($urandom | 32'h8000_0000) : ($urandom & 32'h7FFF_FFFF);
            run_div(OP_SDIV, {$urandom, lo}, {$urandom, ($urandom | 32'h2) & 32'hFFFF_FFFE}, 0);
         end else begin
            write_y($urandom % 64);   // Y below divisor so no overflow
            run_div(OP_UDIV, {$urandom, $urandom}, {$urandom, $urandom | 32'h100}, 1);
         end
      end
   endtask

   task automatic test_ovf();
      write_y(32'h1);
      run_div(OP_UDIV, 64'h0, 64'h1, 0);                   // 2**32 / 1
      run_div(OP_SDIV, 64'h0, 64'hFFFF_FFFF, 0);           // 2**32 / -1
      write_y(32'h0);
      run_div(OP_SDIV, 64'h8000_0000, 64'h1, 2);           // 2**31 / 1
      write_y(32'hFFFF_FFFF);
      run_div(OP_SDIV, 64'h8000_0000, 64'hFFFF_FFFF, 0);   // -2**31 / -1
   endtask

   task automatic test_dbz();
      run_div(OP_UDIVX, {$urandom, $urandom}, 64'h0, 1);
      run_div(OP_SDIVX, 64'h5, 64'h0, 0);
      run_div(OP_SDIV, 64'h7, 64'hABCD_0000_0000_0000, 3);   // Only low half counts
   endtask

   task automatic test_y();
      write_y(32'h1234_5678);
      y_wr_data = 32'hCAFE_F00D;
      y_hold    = 1'b1;   // Write pending through the whole division
      run_div(OP_UDIV, 64'h9876_5432, 64'h8765_4321, 3);
      y_hold    = 1'b0;
      cmp_y("y_value", y_value, y_model);   // Old Y until the first idle edge
      next_cycle();   // Pending write lands here
      y_wr_valid = 1'b0;
      y_model    = 32'hCAFE_F00D;
      cmp_y("y_value", y_value, y_model);
   endtask

   initial begin
      void'($urandom(14485));
      req_valid  = 1'b0;
      req_op     = OP_UDIVX;
      req_rs1    = '0;
      req_rs2    = '0;
      res_ready  = 1'b0;
      y_wr_valid = 1'b0;
      y_wr_data  = '0;
      y_model    = '0;
      y_hold     = 1'b0;
      val_errs   = 0;
      proto_errs = 0;
      arst_n     = 1'b0;
      repeat (2) @(posedge clk);
      #2 arst_n = 1'b1;
      if (res_valid || !req_ready || !y_wr_ready) begin
         proto_errs++;
         $display("Handshake outputs wrong after reset");
      end
      cmp_y("y_value", y_value, y_model);
      test_div64();
      test_div32();
      test_ovf();
      test_dbz();
      test_y();
      $display("Checks done: %0d value errors, %0d protocol errors", val_errs, proto_errs);
      if (val_errs + proto_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+.
div_pkg.sv
div_yreg.sv
div_ctrl.sv
div_datapath.sv
div_fmt.sv
div_top.sv
div_props.sv
tb_div.sv

// File: Makefile
TOP = tb_div
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
